//--- design/vga_pkg.sv
package vga_pkg;

    localparam int COL_W  = 10;
    localparam int ROW_W  = 10;
    localparam int CHAN_W = 4;
    localparam int RGB_W  = 3 * CHAN_W;

    typedef logic [COL_W-1:0]  col_t;
    typedef logic [ROW_W-1:0]  row_t;
    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [RGB_W-1:0]  rgb_t;   // r in [11:8], g in [7:4], b in [3:0]

    // one raster point, 23 bits
    typedef struct packed {
        col_t col;
        row_t row;
        logic visible;
        logic hsync;
        logic vsync;
    } raster_t;

endpackage

//--- design/video_timing.sv
module video_timing import vga_pkg::*; #(
    parameter col_t LAST_VISIBLE_COL = 10'd639,
    parameter col_t H_PULSE_START    = 10'd655,
    parameter col_t H_PULSE_END      = 10'd751,
    parameter col_t LAST_COL         = 10'd799,
    parameter row_t LAST_VISIBLE_ROW = 10'd479,
    parameter row_t V_PULSE_START    = 10'd489,
    parameter row_t V_PULSE_END      = 10'd491,
    parameter row_t LAST_ROW         = 10'd524,
    parameter logic H_POLARITY       = 1'b0,
    parameter logic V_POLARITY       = 1'b0
) (
    input  logic    I_vga_clk,
    input  logic    rst,
    output raster_t raster
);

    col_t col;
    row_t row;
    logic col_vis;
    logic row_vis;
    logic hs;
    logic vs;

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            col     <= '0;
            row     <= '0;
            col_vis <= 1'b1;
            row_vis <= 1'b1;
            hs      <= ~H_POLARITY;
            vs      <= ~V_POLARITY;
        end else begin
            col <= col + 1'b1;

            if (col == LAST_VISIBLE_COL) begin
                col_vis <= 1'b0;   // right edge of active video
            end
            if (col == H_PULSE_START) begin
                hs <= H_POLARITY;
            end
            if (col == H_PULSE_END) begin
                hs <= ~H_POLARITY;
            end

            // end of line, step the row
            if (col == LAST_COL) begin
                col     <= '0;
                col_vis <= 1'b1;
                row     <= row + 1'b1;

                if (row == LAST_VISIBLE_ROW) begin
                    row_vis <= 1'b0;
                end
                if (row == V_PULSE_START) begin
                    vs <= V_POLARITY;
                end
                if (row == V_PULSE_END) begin
                    vs <= ~V_POLARITY;
                end
                if (row == LAST_ROW) begin
                    row     <= '0;
                    row_vis <= 1'b1;
                end
            end
        end
    end

    assign raster = '{
        col:     col,
        row:     row,
        visible: col_vis & row_vis,
        hsync:   hs,
        vsync:   vs
    };

    a_col_range: assert property (@(posedge I_vga_clk) disable iff (rst)
        col <= LAST_COL)
        else $error("column %0d beyond last column", col);

    a_row_range: assert property (@(posedge I_vga_clk) disable iff (rst)
        row <= LAST_ROW)
        else $error("row %0d beyond last row", row);

endmodule

//--- design/pattern_gen.sv
module pattern_gen import vga_pkg::*; (
    input  logic    I_vga_clk,
    input  logic    rst,
    input  raster_t raster,
    output rgb_t    pat_rgb
);

    chan_t red;
    chan_t green;
    chan_t blue;

    // bars across, bars down
    assign red   = raster.col[6:3];
    assign green = raster.row[6:3];

    // 8x8 checker on top
    assign blue = (raster.col[3] ^ raster.row[3]) ? 4'hF : 4'h0;

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            pat_rgb <= '0;
        end else begin
            pat_rgb <= {red, green, blue};
        end
    end

endmodule

//--- design/cursor_overlay.sv
module cursor_overlay import vga_pkg::*; #(
    parameter int CURSOR_SIZE = 8
) (
    input  logic    I_vga_clk,
    input  logic    rst,
    input  raster_t raster,
    input  col_t    cursor_x,
    input  row_t    cursor_y,
    input  rgb_t    cursor_color,
    output logic    cur_hit,
    output rgb_t    cur_rgb
);

    typedef struct packed {
        col_t x;
        row_t y;
        rgb_t color;
    } cursor_t;

    localparam logic [COL_W:0] X_SPAN = (COL_W+1)'(CURSOR_SIZE);
    localparam logic [ROW_W:0] Y_SPAN = (ROW_W+1)'(CURSOR_SIZE);

    cursor_t        in_q;       // inputs at the previous raster point
    cursor_t        frame_cur;  // held for the whole frame
    cursor_t        act;
    logic           frame_start;
    logic [COL_W:0] x_end;
    logic [ROW_W:0] y_end;
    logic           in_x;
    logic           in_y;

    // the point before (0,0) is always (LAST_COL, LAST_ROW), so in_q
    // holds exactly what was on the inputs at the end of the frame
    assign frame_start = (raster.col == '0) && (raster.row == '0);
    assign act         = frame_start ? in_q : frame_cur;

    // one bit wider so x + size never wraps
    assign x_end = {1'b0, act.x} + X_SPAN;
    assign y_end = {1'b0, act.y} + Y_SPAN;
    assign in_x  = (raster.col >= act.x) && ({1'b0, raster.col} < x_end);
    assign in_y  = (raster.row >= act.y) && ({1'b0, raster.row} < y_end);

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            in_q      <= '0;
            frame_cur <= '0;
            cur_hit   <= 1'b0;
            cur_rgb   <= '0;
        end else begin
            in_q <= '{x: cursor_x, y: cursor_y, color: cursor_color};
            if (frame_start) begin
                frame_cur <= in_q;
            end
            cur_hit <= in_x && in_y;
            cur_rgb <= act.color;
        end
    end

endmodule

//--- design/pixel_mixer.sv
module pixel_mixer import vga_pkg::*; (
    input  logic    I_vga_clk,
    input  logic    rst,
    input  raster_t raster,
    input  rgb_t    pat_rgb,
    input  logic    cur_hit,
    input  rgb_t    cur_rgb,
    output rgb_t    rgb,
    output logic    hsync,
    output logic    vsync
);

    logic vis_q;
    logic hs_q;
    logic vs_q;
    rgb_t pix;

    // cursor wins over the pattern
    assign pix = cur_hit ? cur_rgb : pat_rgb;

    // syncs trail the raster by two stages
    always_ff @(posedge I_vga_clk) begin
        hs_q <= raster.hsync;
        vs_q <= raster.vsync;
        if (rst) begin
            hsync <= raster.hsync;   // idle level from the timing block
            vsync <= raster.vsync;
        end else begin
            hsync <= hs_q;
            vsync <= vs_q;
        end
    end

    always_ff @(posedge I_vga_clk) begin
        if (rst) begin
            vis_q <= 1'b0;
            rgb   <= '0;
        end else begin
            vis_q <= raster.visible;   // lines up with pat_rgb / cur_hit
            rgb   <= vis_q ? pix : '0;
        end
    end

    a_blank: assert property (@(posedge I_vga_clk) disable iff (rst)
        !raster.visible |=> ##1 rgb == '0)
        else $error("colour driven for a blanked raster point");

endmodule

//--- design/vga_top.sv
module vga_top import vga_pkg::*; #(
    parameter col_t LAST_VISIBLE_COL = 10'd639,
    parameter col_t H_PULSE_START    = 10'd655,
    parameter col_t H_PULSE_END      = 10'd751,
    parameter col_t LAST_COL         = 10'd799,
    parameter row_t LAST_VISIBLE_ROW = 10'd479,
    parameter row_t V_PULSE_START    = 10'd489,
    parameter row_t V_PULSE_END      = 10'd491,
    parameter row_t LAST_ROW         = 10'd524,
    parameter logic H_POLARITY       = 1'b0,   // 640x480 uses negative syncs
    parameter logic V_POLARITY       = 1'b0,
    parameter int   CURSOR_SIZE      = 8
) (
    input  logic I_vga_clk,
    input  logic rst,
    input  col_t cursor_x,
    input  row_t cursor_y,
    input  rgb_t cursor_color,
    output rgb_t rgb,
    output logic hsync,
    output logic vsync
);

    raster_t raster;
    rgb_t    pat_rgb;
    logic    cur_hit;
    rgb_t    cur_rgb;

    video_timing #(
        .LAST_VISIBLE_COL (LAST_VISIBLE_COL),
        .H_PULSE_START    (H_PULSE_START),
        .H_PULSE_END      (H_PULSE_END),
        .LAST_COL         (LAST_COL),
        .LAST_VISIBLE_ROW (LAST_VISIBLE_ROW),
        .V_PULSE_START    (V_PULSE_START),
        .V_PULSE_END      (V_PULSE_END),
        .LAST_ROW         (LAST_ROW),
        .H_POLARITY       (H_POLARITY),
        .V_POLARITY       (V_POLARITY)
    ) u_timing (
        .I_vga_clk (I_vga_clk),
        .rst       (rst),
        .raster    (raster)
    );

    // these two run side by side on the same raster point
    pattern_gen u_pattern (
        .I_vga_clk (I_vga_clk),
        .rst       (rst),
        .raster    (raster),
        .pat_rgb   (pat_rgb)
    );

    cursor_overlay #(
        .CURSOR_SIZE (CURSOR_SIZE)
    ) u_cursor (
        .I_vga_clk    (I_vga_clk),
        .rst          (rst),
        .raster       (raster),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .cursor_color (cursor_color),
        .cur_hit      (cur_hit),
        .cur_rgb      (cur_rgb)
    );

    pixel_mixer u_mixer (
        .I_vga_clk (I_vga_clk),
        .rst       (rst),
        .raster    (raster),
        .pat_rgb   (pat_rgb),
        .cur_hit   (cur_hit),
        .cur_rgb   (cur_rgb),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync)
    );

endmodule

//--- bench/vga_checks.svh
`ifndef VGA_CHECKS_SVH
`define VGA_CHECKS_SVH

// first error ends the run
task automatic stop_on_error();
    $display("tests failed");
    $fatal(1, "stopping at first error");
endtask

task automatic check_rgb(input string name, input rgb_t want, input rgb_t got);
    if (got !== want) begin
        $display("ERR %0t %s expected %h got %h", $time, name, want, got);
        stop_on_error();
    end
endtask

// single bit results, the syncs
task automatic check_bit(input string name, input logic want, input logic got);
    if (got !== want) begin
        $display("ERR %0t %s expected %b got %b", $time, name, want, got);
        stop_on_error();
    end
endtask

`endif

//--- bench/vga_tb.sv
module vga_tb import vga_pkg::*; ();

    // small frame, 32x16 visible
    localparam col_t LAST_VISIBLE_COL = 10'd31;
    localparam col_t H_PULSE_START    = 10'd33;   // hsync on cols 34..36
    localparam col_t H_PULSE_END      = 10'd36;
    localparam col_t LAST_COL         = 10'd39;
    localparam row_t LAST_VISIBLE_ROW = 10'd15;
    localparam row_t V_PULSE_START    = 10'd16;   // vsync on rows 17..18
    localparam row_t V_PULSE_END      = 10'd18;
    localparam row_t LAST_ROW         = 10'd19;
    localparam logic H_POLARITY       = 1'b1;
    localparam logic V_POLARITY       = 1'b0;
    localparam int   CURSOR_SIZE      = 4;

    localparam int LINE  = int'(LAST_COL) + 1;
    localparam int FRAME = LINE * (int'(LAST_ROW) + 1);
    localparam int LIMIT = 6 * FRAME + 200;   // six frames of tests, reset and drain

    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
    } expect_t;

    logic I_vga_clk = 1'b0;
    logic rst;
    col_t cursor_x;
    row_t cursor_y;
    rgb_t cursor_color;
    rgb_t rgb;
    logic hsync;
    logic vsync;

    // reference raster position and its own cursor latch
    col_t        m_col;
    row_t        m_row;
    col_t        lat_x;
    row_t        lat_y;
    rgb_t        lat_color;
    expect_t     pipe[$];   // two points in flight
    int          cycles = 0;
    logic [31:0] lcg_state = 32'hb398b8d6;

    `include "vga_checks.svh"

    always #4 I_vga_clk = ~I_vga_clk;

    vga_top #(
        .LAST_VISIBLE_COL (LAST_VISIBLE_COL),
        .H_PULSE_START    (H_PULSE_START),
        .H_PULSE_END      (H_PULSE_END),
        .LAST_COL         (LAST_COL),
        .LAST_VISIBLE_ROW (LAST_VISIBLE_ROW),
        .V_PULSE_START    (V_PULSE_START),
        .V_PULSE_END      (V_PULSE_END),
        .LAST_ROW         (LAST_ROW),
        .H_POLARITY       (H_POLARITY),
        .V_POLARITY       (V_POLARITY),
        .CURSOR_SIZE      (CURSOR_SIZE)
    ) dut (
        .I_vga_clk    (I_vga_clk),
        .rst          (rst),
        .cursor_x     (cursor_x),
        .cursor_y     (cursor_y),
        .cursor_color (cursor_color),
        .rgb          (rgb),
        .hsync        (hsync),
        .vsync        (vsync)
    );

    always @(posedge I_vga_clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", LIMIT);
            stop_on_error();
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected outputs for one raster point
    function automatic expect_t expect_point(input col_t c, input row_t r);
        expect_t e;
        logic    vis;
        logic    hit;
        rgb_t    pat;
        vis = (c <= LAST_VISIBLE_COL) && (r <= LAST_VISIBLE_ROW);
        hit = (int'(c) >= int'(lat_x)) && (int'(c) < int'(lat_x) + CURSOR_SIZE)
            && (int'(r) >= int'(lat_y)) && (int'(r) < int'(lat_y) + CURSOR_SIZE);
        pat = {c[6:3], r[6:3], (c[3] != r[3]) ? 4'hF : 4'h0};
        e.rgb   = !vis ? '0 : (hit ? lat_color : pat);
        e.hsync = (c > H_PULSE_START && c <= H_PULSE_END) ? H_POLARITY : ~H_POLARITY;
        e.vsync = (r > V_PULSE_START && r <= V_PULSE_END) ? V_POLARITY : ~V_POLARITY;
        return e;
    endfunction

    // one raster point: queue its expectation, check the one from two cycles back
    task automatic step_point();
        expect_t want;
        @(negedge I_vga_clk);
        pipe.push_back(expect_point(m_col, m_row));
        want = pipe.pop_front();
        check_rgb("rgb", want.rgb, rgb);
        check_bit("hsync", want.hsync, hsync);
        check_bit("vsync", want.vsync, vsync);
        if (m_col == LAST_COL) begin
            if (m_row == LAST_ROW) begin
                lat_x     = cursor_x;   // applies from (0,0) on
                lat_y     = cursor_y;
                lat_color = cursor_color;
                m_row     = '0;
            end else begin
                m_row = m_row + 1'b1;
            end
            m_col = '0;
        end else begin
            m_col = m_col + 1'b1;
        end
    endtask

    task automatic run_points(input int n);
        for (int i = 0; i < n; i++) begin
            step_point();
        end
    endtask

    // stops with the last point of the frame still ahead
    task automatic run_to_last();
        while (!(m_col == LAST_COL && m_row == LAST_ROW)) begin
            step_point();
        end
    endtask

    task automatic drive_cursor(input col_t x, input row_t y, input rgb_t color);
        @(posedge I_vga_clk);
        cursor_x     <= x;
        cursor_y     <= y;
        cursor_color <= color;
    endtask

    task automatic drive_random_cursor();
        logic [31:0] r;
        r = lcg_next();
        drive_cursor(col_t'(r[20:16]), row_t'(r[27:24]), r[11:0]);   // always on screen
    endtask

    task automatic apply_reset();
        $display("test: reset levels");
        repeat (2) @(posedge I_vga_clk);
        @(negedge I_vga_clk);
        check_rgb("rgb", '0, rgb);
        check_bit("hsync", ~H_POLARITY, hsync);
        check_bit("vsync", ~V_POLARITY, vsync);
        @(posedge I_vga_clk);
        rst <= 1'b0;
        m_col     = '0;
        m_row     = '0;
        lat_x     = '0;
        lat_y     = '0;
        lat_color = '0;
        pipe.delete();
        // outputs stay idle until (0,0) comes out
        repeat (2) pipe.push_back(expect_t'{rgb: '0, hsync: ~H_POLARITY, vsync: ~V_POLARITY});
    endtask

    task automatic test_sync();
        $display("test: sync timing over one frame");
        run_to_last();
    endtask

    task automatic test_pattern();
        $display("test: pattern and blanking, cursor off screen");
        drive_cursor(10'd1000, 10'd1000, 12'hFFF);
        step_point();
        run_to_last();
    endtask

    task automatic test_cursor();
        logic [31:0] r;
        $display("test: random cursor");
        drive_random_cursor();
        step_point();
        run_to_last();
        $display("test: cursor clipped at the corner");
        r = lcg_next();
        drive_cursor(LAST_VISIBLE_COL - 10'd1, LAST_VISIBLE_ROW - 10'd1, r[11:0]);
        step_point();
        run_to_last();
    endtask

    task automatic test_latch();
        logic [31:0] r;
        $display("test: cursor change mid frame");
        drive_random_cursor();
        step_point();
        run_points(2 * LINE + 5);
        r = lcg_next();
        drive_cursor(cursor_x ^ 10'd16, row_t'(r[27:24]), r[11:0]);
        run_to_last();   // old cursor until the frame ends
        step_point();
        run_to_last();   // new one for the whole frame
        step_point();
    endtask

    initial begin
        rst          = 1'b1;
        cursor_x     = '0;
        cursor_y     = '0;
        cursor_color = '0;
        apply_reset();
        test_sync();
        test_pattern();
        test_cursor();
        test_latch();
        run_points(2);   // flush the last two points
        $display("all tests passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+bench
design/vga_pkg.sv
design/video_timing.sv
design/pattern_gen.sv
design/cursor_overlay.sv
design/pixel_mixer.sv
design/vga_top.sv
bench/vga_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench, run it into sim.log, then look for the failure line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module vga_tb -f src.f -o vga_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/vga_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
